// ==== include/icache_macros.svh ====
// organization constants for the two-way instruction cache
// included by the packages and by the modules that size loops or slice addresses
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// sets and ways
`define ICACHE_SETS 64
`define ICACHE_WAYS 2

// width of one per-way age counter
`define ICACHE_AGE_W 3

// fetch address fields
`define ICACHE_TAG_LSB 9
`define ICACHE_INDEX_LSB 3
`define ICACHE_WORD_BIT 2

// one cleared set per cycle
`define ICACHE_FENCE_CYCLES 64

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module icache_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vicache_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== sim/icache_patterns.txt ====
# op value miss, one operation per line
# value: hex fetch address, or hex cycle count for fence and stall; miss 1 expects one refill
fetch 00001000 1
fetch 00001000 0
fetch 00001004 0
fetch 00001ffc 1
fetch 00001ff8 0
# set 5 with tags 0, 1 and 2
fetch 00000028 1
fetch 00000228 1
fetch 00000028 0
fetch 0000022c 0
# tag 0 sits in the older way and is evicted
fetch 00000428 1
fetch 00000228 0
fetch 00000028 1
# fence longer than the sweep
fence 00000050 0
fetch 00001000 1
fetch 00001ffc 1
fetch 00000028 1
fetch 00000428 1
# stalls on hits and on a refill
stall 00000006 0
fetch 00001004 0
stall 00000003 0
fetch 0000042c 0
stall 00000010 0
fetch 00000628 1
fetch 0000042c 0
fetch 0000002c 1

// ==== sim/icache_tb.sv ====
// testbench for the two-way instruction cache
// replays sim/icache_patterns.txt against a 64-bit refill memory and checks each word
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_tb;
    import icache_pkg::*;
    import fetch_pkg::*;

    // cycle budget per pattern with room for the slowest refill
    localparam int          WORST_CYCLES = 24;
    localparam logic [31:0] DATA_KEY     = 32'h5A5A_5A5A;
    localparam logic [15:0] LFSR_TAPS    = 16'hB400;

    logic        clk;
    logic        rst_n_i;
    logic        fetch_req_i;
    fetch_addr_t fetch_addr_i;
    logic        fetch_stall_i;
    logic        fence_i;
    inst_t       fetch_inst_o;
    logic        fetch_valid_o;
    logic        mem_req_o;
    fetch_addr_t mem_addr_o;
    line_t       mem_data_i;
    logic        mem_valid_i;

    string       op_q[$];
    fetch_addr_t value_q[$];
    int          miss_q[$];
    int          line_q[$];
    int          limit_cycles    = 0;
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          mem_requests    = 0;
    fetch_addr_t last_mem_addr   = '0;
    logic [15:0] lfsr            = 16'd4823;

    tb_clkgen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (2)
    ) clkgen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    icache_top icache_top_i (.*);

    // galois lfsr stepped once per returned bit
    function automatic int draw_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    // each memory word is derived from its own address
    function automatic line_t build_line(input fetch_addr_t line_addr);
        return {(line_addr + 32'd4) ^ DATA_KEY, line_addr ^ DATA_KEY};
    endfunction

    function automatic inst_t expected_word(input fetch_addr_t addr);
        fetch_addr_t line_addr;
        line_addr = {addr[31:3], 3'b000};
        return addr[2] ? ((line_addr + 32'd4) ^ DATA_KEY) : (line_addr ^ DATA_KEY);
    endfunction

    task automatic load_patterns(output bit loaded);
        int          fd;
        int          line_no;
        int          miss;
        int          extra;
        string       text;
        fetch_addr_t value;
        loaded  = 1'b0;
        line_no = 0;
        extra   = 0;
        fd = $fopen("sim/icache_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = "";
                line_no++;
                if ($fgets(text, fd) > 0 && text.len() > 6 && text.getc(0) != "#") begin
                    if ($sscanf(text.substr(5, text.len() - 1), "%h %d", value, miss) == 2) begin
                        op_q.push_back(text.substr(0, 4));
                        value_q.push_back(value);
                        miss_q.push_back(miss);
                        line_q.push_back(line_no);
                        if (text.substr(0, 4) != "fetch") begin
                            extra += int'(value) + 4;
                        end
                    end
                end
            end
            $fclose(fd);
            limit_cycles = op_q.size() * WORST_CYCLES + extra + `ICACHE_FENCE_CYCLES;
            loaded = (op_q.size() > 0);
        end
    endtask

    task automatic fetch_and_check(input string name, input fetch_addr_t addr, input int miss,
                                   input int stall);
        int          requests;
        inst_t       got;
        fetch_addr_t line_addr;
        line_addr = {addr[31:3], 3'b000};
        requests  = mem_requests;
        @(posedge clk);
        #1;
        fetch_req_i   = 1'b1;
        fetch_addr_i  = addr;
        fetch_stall_i = (stall > 0);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            assert (!fetch_valid_o) else begin
                $display("%0s: fetch_valid_o went high while the core stalled", name);
                protocol_errors++;
            end
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            fetch_stall_i = 1'b0;
        end
        @(negedge clk);
        while (!fetch_valid_o) begin
            @(negedge clk);
        end
        got      = fetch_inst_o;
        requests = mem_requests - requests;
        @(posedge clk);
        #1;
        fetch_req_i = 1'b0;
        @(negedge clk);
        assert (!fetch_valid_o) else begin
            $display("%0s: fetch_valid_o stayed high for a second cycle", name);
            protocol_errors++;
        end
        assert (requests == miss) else begin
            $display("ERR %0s memory requests expected %0d actual %0d", name, miss, requests);
            value_errors++;
        end
        assert (requests != 1 || last_mem_addr == line_addr) else begin
            $display("ERR %0s refill address expected %08h actual %08h",
                     name, line_addr, last_mem_addr);
            value_errors++;
        end
        assert (got == expected_word(addr)) else begin
            $display("ERR %0s word expected %08h actual %08h", name, expected_word(addr), got);
            value_errors++;
        end
    endtask

    task automatic hold_fence(input string name, input int cycles);
        @(posedge clk);
        #1;
        fence_i = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!fetch_valid_o && !mem_req_o) else begin
                $display("%0s: fetch or memory activity during the fence", name);
                protocol_errors++;
            end
        end
        @(posedge clk);
        #1;
        fence_i = 1'b0;
    endtask

    // answers each refill after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        forever begin
            @(negedge clk);
            if (rst_n_i && mem_req_o) begin
                mem_requests++;
                last_mem_addr = mem_addr_o;
                delay = 1 + draw_bits(2);
                for (int i = 1; i < delay; i++) begin
                    @(negedge clk);
                    assert (mem_req_o) else begin
                        $display("mem_req_o dropped before the memory answered");
                        protocol_errors++;
                    end
                end
                @(posedge clk);
                #1;
                mem_valid_i = 1'b1;
                mem_data_i  = build_line(last_mem_addr);
                @(posedge clk);
                #1;
                mem_valid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        bit    loaded;
        int    stall_next;
        string name;
        fetch_req_i   = 1'b0;
        fetch_addr_i  = '0;
        fetch_stall_i = 1'b0;
        fence_i       = 1'b0;
        stall_next    = 0;
        load_patterns(loaded);
        if (!loaded) begin
            $display("pattern file sim/icache_patterns.txt is missing or empty");
            $display("Errors found");
            $finish;
        end else begin
            wait (rst_n_i === 1'b1);
            @(negedge clk);
            assert (!fetch_valid_o && !mem_req_o) else begin
                $display("fetch_valid_o or mem_req_o high right after reset");
                protocol_errors++;
            end
            for (int k = 0; k < op_q.size(); k++) begin
                name = $sformatf("%0s_%08h_line%0d", op_q[k], value_q[k], line_q[k]);
                if (op_q[k] == "fetch") begin
                    fetch_and_check(name, value_q[k], miss_q[k], stall_next);
                    stall_next = 0;
                end else if (op_q[k] == "fence") begin
                    hold_fence(name, int'(value_q[k]));
                end else if (op_q[k] == "stall") begin
                    stall_next = int'(value_q[k]);
                end else begin
                    $display("%0s: unknown operation in the pattern file", name);
                    protocol_errors++;
                end
            end
            repeat (4) @(posedge clk);
            $display("done: %0d patterns, %0d value errors, %0d protocol errors",
                     op_q.size(), value_errors, protocol_errors);
            if (value_errors + protocol_errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
// clock and reset source for the cache testbench
// reset is released just after a rising edge, like every other tb input
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/fetch_pkg.sv ====
// core and memory side types, plus the controller state encoding
`default_nettype none

`include "icache_macros.svh"

package fetch_pkg;

    typedef logic [31:0] fetch_addr_t;
    typedef logic [31:0] inst_t;

    // one extra bit so the sweep can count past the last set
    typedef logic [$clog2(`ICACHE_FENCE_CYCLES):0] fence_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        DELIVER,
        REFILL,
        FENCE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/icache_ctrl.sv ====
// fetch controller for lookup, refill from memory, delivery to the core and fence sweep
// drives both ways through their way_if and feeds the replacement unit
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  fetch_pkg::fetch_addr_t fetch_addr_i,
    input  logic                   fetch_stall_i,
    input  logic                   fence_i,
    output fetch_pkg::inst_t       fetch_inst_o,
    output logic                   fetch_valid_o,
    output logic                   mem_req_o,
    output fetch_pkg::fetch_addr_t mem_addr_o,
    input  icache_pkg::line_t      mem_data_i,
    input  logic                   mem_valid_i,
    way_if.ctrl                    way0,
    way_if.ctrl                    way1,
    input  icache_pkg::way_sel_t   victim_i,
    output logic                   touch_o,
    output icache_pkg::way_sel_t   touch_way_o,
    output logic                   step_o,
    output logic                   valid0_o,
    output logic                   valid1_o
);
    import icache_pkg::*;
    import fetch_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    fence_cnt_t  fence_cnt_q;
    logic        fence_done;
    logic        fence_wr;
    logic        fill_q;
    logic        fill_wr;
    line_t       fill_line_q;
    way_sel_t    hit_way_q;
    index_t      fetch_index;
    index_t      lookup_index;
    tag_entry_t  wr_entry;
    line_t       wr_line;

    assign fetch_index = fetch_addr_i[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign fence_done  = (fence_cnt_q == fence_cnt_t'(`ICACHE_FENCE_CYCLES));
    assign fence_wr    = (state_q == FENCE) && !fence_done;
    // second refill cycle writes the captured line
    assign fill_wr     = (state_q == REFILL) && fill_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fence_i) begin
                    state_d = FENCE;
                end else if (fetch_req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = (way0.hit || way1.hit) ? DELIVER : REFILL;
            end
            DELIVER: begin
                if (!fetch_stall_i) begin
                    state_d = IDLE;
                end
            end
            REFILL: begin
                if (fill_q) begin
                    state_d = LOOKUP;
                end
            end
            FENCE: begin
                if (fence_done && !fence_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            fence_cnt_q <= '0;
            fill_q      <= 1'b0;
            hit_way_q   <= '0;
            valid0_o    <= 1'b0;
            valid1_o    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                fence_cnt_q <= '0;
            end else if (fence_wr) begin
                fence_cnt_q <= fence_cnt_q + 1'b1;
            end
            fill_q <= (state_q == REFILL) && !fill_q && mem_valid_i;
            if (state_q == LOOKUP) begin
                hit_way_q <= way1.hit ? way_sel_t'(1) : way_sel_t'(0);
                valid0_o  <= way0.valid;
                valid1_o  <= way1.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == REFILL) && mem_valid_i) begin
            fill_line_q <= mem_data_i;
        end
    end

    // the fence sweep indexes by its counter and every other state by the fetch set
    assign lookup_index = fence_wr ? fence_cnt_q[$bits(index_t)-1:0] : fetch_index;
    assign wr_entry     = fence_wr
                        ? tag_entry_t'(0)
                        : tag_entry_t'{valid: 1'b1, tag: fetch_addr_i[31:`ICACHE_TAG_LSB]};
    assign wr_line      = fence_wr ? line_t'(0) : fill_line_q;

    assign way0.index    = lookup_index;
    assign way0.tag      = fetch_addr_i[31:`ICACHE_TAG_LSB];
    assign way0.word     = fetch_addr_i[`ICACHE_WORD_BIT];
    assign way0.we       = fence_wr || (fill_wr && (victim_i == way_sel_t'(0)));
    assign way0.wr_entry = wr_entry;
    assign way0.wr_line  = wr_line;

    assign way1.index    = lookup_index;
    assign way1.tag      = fetch_addr_i[31:`ICACHE_TAG_LSB];
    assign way1.word     = fetch_addr_i[`ICACHE_WORD_BIT];
    assign way1.we       = fence_wr || (fill_wr && (victim_i == way_sel_t'(1)));
    assign way1.wr_entry = wr_entry;
    assign way1.wr_line  = wr_line;

    assign fetch_valid_o = (state_q == DELIVER) && !fetch_stall_i;
    assign fetch_inst_o  = (hit_way_q == way_sel_t'(1)) ? way1.inst : way0.inst;

    assign mem_req_o  = (state_q == REFILL) && !fill_q;
    assign mem_addr_o = {fetch_addr_i[31:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};

    // ages move only on an accepted delivery
    assign step_o      = fetch_valid_o;
    assign touch_o     = fetch_valid_o;
    assign touch_way_o = hit_way_q;

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
// cache organization types shared by the ways, the replacement unit and the controller
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // one line holds 2^INDEX_LSB bytes
    localparam int LINE_W = 8 << `ICACHE_INDEX_LSB;

    typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;
    typedef logic [31-`ICACHE_TAG_LSB:0]     tag_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [LINE_W-1:0]              line_t;
    typedef logic [`ICACHE_AGE_W-1:0]       age_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_sel_t;

endpackage

`default_nettype wire

// ==== src/icache_replace.sv ====
// per-set, per-way saturating age counters and victim choice
// step ages everything on a delivery, touch clears the way just used
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_replace (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  icache_pkg::index_t   index_i,
    input  logic                 way0_valid_i,
    input  logic                 way1_valid_i,
    input  logic                 touch_i,
    input  icache_pkg::way_sel_t touch_way_i,
    input  logic                 step_i,
    output icache_pkg::way_sel_t victim_o
);
    import icache_pkg::*;

    age_t age_q [`ICACHE_SETS][`ICACHE_WAYS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else begin
            if (step_i) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    for (int w = 0; w < `ICACHE_WAYS; w++) begin
                        if (age_q[s][w] != '1) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
            end
            // later assignment, so the clear beats the increment
            if (touch_i) begin
                age_q[index_i][touch_way_i] <= '0;
            end
        end
    end

    // empty way first, then the older one, ties go to way 0
    always_comb begin
        if (!way0_valid_i) begin
            victim_o = way_sel_t'(0);
        end else if (!way1_valid_i) begin
            victim_o = way_sel_t'(1);
        end else if (age_q[index_i][0] >= age_q[index_i][1]) begin
            victim_o = way_sel_t'(0);
        end else begin
            victim_o = way_sel_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
// two-way instruction cache top level
// core fetch port and 64-bit memory refill port, both request/valid
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  fetch_pkg::fetch_addr_t fetch_addr_i,
    input  logic                   fetch_stall_i,
    input  logic                   fence_i,
    output fetch_pkg::inst_t       fetch_inst_o,
    output logic                   fetch_valid_o,
    output logic                   mem_req_o,
    output fetch_pkg::fetch_addr_t mem_addr_o,
    input  icache_pkg::line_t      mem_data_i,
    input  logic                   mem_valid_i
);
    import icache_pkg::*;

    way_sel_t victim;
    way_sel_t touch_way;
    logic     touch;
    logic     step;
    logic     valid0;
    logic     valid1;

    way_if way0_bus ();
    way_if way1_bus ();

    icache_ctrl ctrl_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_stall_i (fetch_stall_i),
        .fence_i       (fence_i),
        .fetch_inst_o  (fetch_inst_o),
        .fetch_valid_o (fetch_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_i    (mem_data_i),
        .mem_valid_i   (mem_valid_i),
        .way0          (way0_bus.ctrl),
        .way1          (way1_bus.ctrl),
        .victim_i      (victim),
        .touch_o       (touch),
        .touch_way_o   (touch_way),
        .step_o        (step),
        .valid0_o      (valid0),
        .valid1_o      (valid1)
    );

    icache_way way0_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .port    (way0_bus.way)
    );

    icache_way way1_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .port    (way1_bus.way)
    );

    // both ways share one index, way 0 carries it here
    icache_replace replace_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .index_i      (way0_bus.index),
        .way0_valid_i (valid0),
        .way1_valid_i (valid1),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .step_i       (step),
        .victim_o     (victim)
    );

endmodule

`default_nettype wire

// ==== src/icache_way.sv ====
// one cache way with its tag store and line store
// hit and instruction are valid the cycle after the index
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_way (
    input  logic clk,
    input  logic rst_n_i,
    way_if.way   port
);
    import icache_pkg::*;

    tag_entry_t entry_q;
    line_t      line_q;
    tag_t       tag_q;
    logic       word_q;

    // lookup key lines up with the registered array output
    always_ff @(posedge clk) begin
        tag_q  <= port.tag;
        word_q <= port.word;
    end

    line_array #(
        .entry_t (tag_entry_t),
        .DEPTH   (`ICACHE_SETS)
    ) tag_array (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_index_i (port.index),
        .wr_en_i    (port.we),
        .wr_index_i (port.index),
        .wr_data_i  (port.wr_entry),
        .rd_data_o  (entry_q)
    );

    line_array #(
        .entry_t (line_t),
        .DEPTH   (`ICACHE_SETS)
    ) data_array (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_index_i (port.index),
        .wr_en_i    (port.we),
        .wr_index_i (port.index),
        .wr_data_i  (port.wr_line),
        .rd_data_o  (line_q)
    );

    assign port.valid = entry_q.valid;
    assign port.hit   = entry_q.valid && (entry_q.tag == tag_q);
    // upper word when address bit 2 is set
    assign port.inst  = word_q ? line_q[63:32] : line_q[31:0];

endmodule

`default_nettype wire

// ==== src/line_array.sv ====
// registered-read storage array, one entry per set
// entry type is a parameter so tags and line payloads share this block
`timescale 1ns/1ps
`default_nettype none

module line_array #(
    parameter type entry_t = logic [63:0],
    parameter int  DEPTH   = 64
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  icache_pkg::index_t rd_index_i,
    input  logic               wr_en_i,
    input  icache_pkg::index_t wr_index_i,
    input  entry_t             wr_data_i,
    output entry_t             rd_data_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_en_i) begin
                mem[wr_index_i] <= wr_data_i;
            end
            // write-first, a lookup right after a fill sees the new entry
            if (wr_en_i && (wr_index_i == rd_index_i)) begin
                rd_data_o <= wr_data_i;
            end else begin
                rd_data_o <= mem[rd_index_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/way_if.sv ====
// lookup and write bundle between the controller and one cache way
// one instance per way, controller drives the address and write side
`timescale 1ns/1ps
`default_nettype none

interface way_if;
    import icache_pkg::*;
    import fetch_pkg::*;

    index_t     index;
    tag_t       tag;
    logic       word;
    logic       we;
    tag_entry_t wr_entry;
    line_t      wr_line;

    // lookup result, one cycle after index
    logic       hit;
    logic       valid;
    inst_t      inst;

    modport ctrl (
        output index, tag, word, we, wr_entry, wr_line,
        input  hit, valid, inst
    );

    modport way (
        input  index, tag, word, we, wr_entry, wr_line,
        output hit, valid, inst
    );

endinterface

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/icache_pkg.sv
src/fetch_pkg.sv
src/way_if.sv
src/line_array.sv
src/icache_way.sv
src/icache_replace.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/tb_clkgen.sv
sim/icache_tb.sv
